// File: branch_resolver.sv
`default_nettype none

module branch_resolver
	import fetch_pkg::*;
#(
	parameter int addr_width = fetch_pkg::addr_width
) (
	input  wire logic                  clk,
	input  wire logic                  reset,
	fetch_if.resolve                   dec,
	input  wire logic                  stall,
	input  wire logic                  cond,
	output logic                       misprediction,
	output logic [addr_width-1:0]      correct_pc
);

	logic beq_live;
	logic pending_taken;
	logic [addr_width-1:0] pending_target;

	// Only a live branch counts
	assign beq_live = dec.live && (dec.op == op_beq);

	////////////////////
	// Pending branch

	// Fetch went not-taken, so a taken cond is a miss
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			pending_taken <= 1'b0;
		end else if (!stall) begin
			pending_taken <= beq_live && cond;
		end
	end

	// Target of the branch, held across a stall
	always_ff @(posedge clk) begin
		if (!stall && beq_live) begin
			pending_target <= dec.pc + dec.imm;
		end
	end

	////////////////////
	// Redirect

	// Fires for one unstalled cycle, the cycle after the branch
	assign misprediction = pending_taken && !stall;
	assign correct_pc = pending_target;

endmodule

`default_nettype wire

// File: fetch_if.sv
`default_nettype none

interface fetch_if
	import fetch_pkg::*;
#(
	parameter int addr_width = fetch_pkg::addr_width
);

	// PC of the word in this slot
	logic [addr_width-1:0] pc;
	// Decoded operation
	opcode_t op;
	// Immediate already sign-extended to the PC width
	logic [addr_width-1:0] imm;
	// Slot is neither stalled nor squashed
	logic live;

	// Predecoder drives the slot
	modport decode (output pc, op, imm, live);

	// PC controller only needs the op and its immediate
	modport ctrl (input op, imm, live);

	// Resolver forms branch targets from pc and imm
	modport resolve (input pc, op, imm, live);

endinterface

`default_nettype wire

// File: fetch_pc_ctrl.sv
`default_nettype none

module fetch_pc_ctrl
	import fetch_pkg::*;
#(
	parameter int addr_width = fetch_pkg::addr_width
) (
	input  wire logic                  clk,
	input  wire logic                  reset,
	input  wire logic                  bubble,
	fetch_if.ctrl                      dec,
	input  wire logic                  misprediction,
	input  wire logic [addr_width-1:0] correct_pc,
	output logic [addr_width-1:0]      current_pc,
	output logic [addr_width-1:0]      pc_save,
	output logic                       save_valid
);

	logic [addr_width-1:0] pc_reg;
	logic [addr_width-1:0] pc_plus_one;
	logic [addr_width-1:0] pc_plus_imm;
	logic [addr_width-1:0] pc_pred;
	logic [addr_width-1:0] pc_next;

	////////////////////
	// PC register

	// Frozen on a bubble
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			pc_reg <= '0;
		end else if (!bubble) begin
			pc_reg <= pc_next;
		end
	end

	assign current_pc = pc_reg;

	// Word addressed, so sequential fetch is plus one
	assign pc_plus_one = pc_reg + addr_width'(1);
	assign pc_plus_imm = pc_reg + dec.imm;

	////////////////////
	// Next PC and save value

	always_comb begin
		// Sequential path, also the not-taken guess for beq
		pc_pred    = pc_plus_one;
		// AUIPC result by default
		pc_save    = pc_plus_imm;
		save_valid = 1'b0;
		if (dec.live) begin
			case (dec.op)
				// jalr target guessed as pc plus imm too
				op_jal, op_jalr: begin
					pc_pred    = pc_plus_imm;
					pc_save    = pc_plus_one;
					save_valid = 1'b1;
				end
				// Result only, PC keeps going
				op_auipc: save_valid = 1'b1;
				default: pc_pred = pc_plus_one;
			endcase
		end
	end

	// Resolver correction wins over any prediction
	assign pc_next = misprediction ? correct_pc : pc_pred;

endmodule

`default_nettype wire

// File: fetch_pkg.sv
`default_nettype none

package fetch_pkg;

	////////////////////
	// Sizes

	// Default PC and instruction address width, counted in words
	parameter int addr_width = 16;

	////////////////////
	// Instruction format

	// One fetched word
	typedef logic [31:0] instr_t;

	// Opcode sits in the top nibble
	localparam int op_msb = 31;
	localparam int op_lsb = 28;

	// Immediate in the low half word, sign bit at imm_msb
	localparam int imm_msb = 15;

	// Operations known to the front end
	typedef enum logic [3:0] {
		op_nop   = 4'h0,
		op_jal   = 4'h1,
		op_jalr  = 4'h2,
		op_auipc = 4'h3,
		op_beq   = 4'h4
	} opcode_t;

	////////////////////
	// Load port

	// Four-phase handshake on the memory side
	typedef enum logic [1:0] {
		idle         = 2'd0,
		write        = 2'd1,
		wait_release = 2'd2
	} load_state_t;

endpackage

`default_nettype wire

// File: fetch_unit_top.sv
`default_nettype none

module fetch_unit_top
	import fetch_pkg::*;
#(
	parameter int addr_width = fetch_pkg::addr_width,
	parameter int mem_depth  = 64
) (
	input  wire logic                  clk,
	input  wire logic                  reset,
	input  wire logic                  cond,
	input  wire logic                  load_req,
	input  wire logic [addr_width-1:0] load_addr,
	input  wire instr_t                load_data,
	output logic                       load_ack,
	output logic [addr_width-1:0]      pc,
	output logic [addr_width-1:0]      pc_save,
	output logic                       save_valid,
	output logic                       redirect
);

	// Memory busy doubles as stall and bubble
	logic busy;
	instr_t fetch_word;
	logic [addr_width-1:0] correct_pc;

	// Decoded slot shared by controller and resolver
	fetch_if #(.addr_width(addr_width)) dec_bus ();

	////////////////////
	// Memory

	instr_mem #(
		.addr_width (addr_width),
		.mem_depth  (mem_depth)
	) u_instr_mem (
		.clk       (clk),
		.reset     (reset),
		.rd_addr   (pc),
		.rd_data   (fetch_word),
		.load_req  (load_req),
		.load_addr (load_addr),
		.load_data (load_data),
		.load_ack  (load_ack),
		.busy      (busy)
	);

	////////////////////
	// Decode and resolve

	// Redirect also squashes the wrong-path slot
	instr_predecode #(.addr_width(addr_width)) u_instr_predecode (
		.instr  (fetch_word),
		.pc     (pc),
		.stall  (busy),
		.squash (redirect),
		.dec    (dec_bus.decode)
	);

	branch_resolver #(.addr_width(addr_width)) u_branch_resolver (
		.clk           (clk),
		.reset         (reset),
		.dec           (dec_bus.resolve),
		.stall         (busy),
		.cond          (cond),
		.misprediction (redirect),
		.correct_pc    (correct_pc)
	);

	////////////////////
	// PC

	fetch_pc_ctrl #(.addr_width(addr_width)) u_fetch_pc_ctrl (
		.clk           (clk),
		.reset         (reset),
		.bubble        (busy),
		.dec           (dec_bus.ctrl),
		.misprediction (redirect),
		.correct_pc    (correct_pc),
		.current_pc    (pc),
		.pc_save       (pc_save),
		.save_valid    (save_valid)
	);

endmodule

`default_nettype wire

// File: instr_mem.sv
`default_nettype none

module instr_mem
	import fetch_pkg::*;
#(
	parameter int addr_width = fetch_pkg::addr_width,
	parameter int mem_depth  = 64
) (
	input  wire logic                  clk,
	input  wire logic                  reset,
	input  wire logic [addr_width-1:0] rd_addr,
	output instr_t                     rd_data,
	input  wire logic                  load_req,
	input  wire logic [addr_width-1:0] load_addr,
	input  wire instr_t                load_data,
	output logic                       load_ack,
	output logic                       busy
);

	localparam int idx_width = $clog2(mem_depth);

	instr_t mem [mem_depth];
	load_state_t state;

	////////////////////
	// Fetch read

	// Combinational read, addresses past the end read as nop
	assign rd_data = (rd_addr < mem_depth) ? mem[rd_addr[idx_width-1:0]] : '0;

	////////////////////
	// Load handshake

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state <= idle;
		end else begin
			case (state)
				// Wait for a request with address and data stable
				idle: if (load_req) state <= write;
				// Word goes in this cycle
				write: state <= wait_release;
				// Ack stays up until the requester lets go
				wait_release: if (!load_req) state <= idle;
				default: state <= idle;
			endcase
		end
	end

	// Array write, one word per handshake
	always_ff @(posedge clk) begin
		if (state == write && load_addr < mem_depth) begin
			mem[load_addr[idx_width-1:0]] <= load_data;
		end
	end

	assign load_ack = (state == wait_release);

	// Fetch must hold off for the whole handshake
	assign busy = (state != idle) || load_req;

endmodule

`default_nettype wire

// File: instr_predecode.sv
`default_nettype none

module instr_predecode
	import fetch_pkg::*;
#(
	parameter int addr_width = fetch_pkg::addr_width
) (
	input  wire instr_t                instr,
	input  wire logic [addr_width-1:0] pc,
	input  wire logic                  stall,
	input  wire logic                  squash,
	fetch_if.decode                    dec
);

	// Top nibble to opcode
	always_comb begin
		case (instr[op_msb:op_lsb])
			op_jal:   dec.op = op_jal;
			op_jalr:  dec.op = op_jalr;
			op_auipc: dec.op = op_auipc;
			op_beq:   dec.op = op_beq;
			// Unknown codes behave as nop
			default:  dec.op = op_nop;
		endcase
	end

	// Sign-extend the low half word to the PC width
	assign dec.imm = addr_width'($signed(instr[imm_msb:0]));

	// Slot carries its own PC for target math downstream
	assign dec.pc = pc;

	// Wrong-path slot after a taken branch and stalled slots do nothing
	assign dec.live = !stall && !squash;

endmodule

`default_nettype wire

// File: project.f
fetch_pkg.sv
fetch_if.sv
instr_mem.sv
instr_predecode.sv
branch_resolver.sv
fetch_pc_ctrl.sv
fetch_unit_top.sv
tb_fetch_unit.sv

// File: tb_fetch_unit.sv
`default_nettype none

module tb_fetch_unit
	import fetch_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int pc_width = fetch_pkg::addr_width;
	localparam int depth = 64;
	// Cycles allowed for each handshake phase
	localparam int handshake_limit = 20;

	logic clk;
	logic reset;
	logic cond;
	logic load_req;
	logic [pc_width-1:0] load_addr;
	instr_t load_data;
	logic load_ack;
	logic [pc_width-1:0] pc;
	logic [pc_width-1:0] pc_save;
	logic save_valid;
	logic redirect;

	// Testbench copy of the memory image
	instr_t prog [depth];
	// Reference model state
	logic [pc_width-1:0] m_pc;
	logic m_pend;
	logic [pc_width-1:0] m_tgt;
	logic [31:0] lfsr_state;
	int error_count;

	fetch_unit_top #(
		.addr_width (pc_width),
		.mem_depth  (depth)
	) u_fetch_unit_top (
		.clk        (clk),
		.reset      (reset),
		.cond       (cond),
		.load_req   (load_req),
		.load_addr  (load_addr),
		.load_data  (load_data),
		.load_ack   (load_ack),
		.pc         (pc),
		.pc_save    (pc_save),
		.save_valid (save_valid),
		.redirect   (redirect)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	////////////////////
	// Compare tasks

	task automatic check_pc(string name, logic [pc_width-1:0] expected,
			logic [pc_width-1:0] actual);
		if (actual !== expected) begin
			error_count++;
			$display("** Error %s expected %h actual %h at %0t", name, expected, actual, $time);
		end
	endtask

	task automatic check_save(string name, logic [pc_width-1:0] expected,
			logic [pc_width-1:0] actual);
		if (actual !== expected) begin
			error_count++;
			$display("** Error %s expected %h actual %h at %0t", name, expected, actual, $time);
		end
	endtask

	task automatic check_bit(string name, logic expected, logic actual);
		if (actual !== expected) begin
			error_count++;
			$display("** Error %s expected %h actual %h at %0t", name, expected, actual, $time);
		end
	endtask

	////////////////////
	// Random bits

	// Taps 32 22 2 1
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		return fb;
	endfunction

	function automatic int lfsr_bits(int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			v = (v << 1) | int'(lfsr_bit());
		end
		return v;
	endfunction

	////////////////////
	// Program image

	function automatic instr_t make_word(opcode_t op, int imm);
		return {op, 12'h000, 16'(imm)};
	endfunction

	// Filler nops carry their own address as immediate
	task automatic clear_program();
		for (int a = 0; a < depth; a++) begin
			prog[a] = make_word(op_nop, a);
		end
	endtask

	task automatic report_timeout(string what);
		$display("Timeout while waiting for %s", what);
		$display("Checks finished with %0d value errors", error_count);
		$display("Testbench failed");
		$finish;
	endtask

	// Fetch must look frozen while the loader is busy
	task automatic check_stalled();
		check_pc("pc", m_pc, pc);
		check_bit("save_valid", 1'b0, save_valid);
		check_bit("redirect", 1'b0, redirect);
	endtask

	// Starts and ends on a falling edge
	task automatic load_word(int addr, instr_t data);
		int count;
		load_addr = pc_width'(addr);
		load_data = data;
		load_req = 1'b1;
		cond = 1'b0;
		count = 0;
		while (load_ack !== 1'b1 && count < handshake_limit) begin
			@(negedge clk);
			count++;
			check_stalled();
		end
		if (load_ack !== 1'b1) report_timeout($sformatf("load_ack to rise, address %0h", addr));
		load_req = 1'b0;
		count = 0;
		// PC still held until ack drops
		while (load_ack !== 1'b0 && count < handshake_limit) begin
			@(negedge clk);
			count++;
			check_pc("pc", m_pc, pc);
		end
		if (load_ack !== 1'b0) report_timeout($sformatf("load_ack to fall, address %0h", addr));
		prog[addr] = data;
	endtask

	task automatic load_program();
		for (int a = 0; a < depth; a++) begin
			load_word(a, prog[a]);
		end
	endtask

	// Memory contents survive reset
	task automatic do_reset();
		@(negedge clk);
		reset = 1'b0;
		cond = 1'b0;
		load_req = 1'b0;
		repeat (8) @(negedge clk);
		reset = 1'b1;
		m_pc = '0;
		m_pend = 1'b0;
		check_pc("pc", '0, pc);
		check_bit("save_valid", 1'b0, save_valid);
		check_bit("redirect", 1'b0, redirect);
		check_bit("load_ack", 1'b0, load_ack);
	endtask

	////////////////////
	// Reference model

	// cond_mode 0 low, 1 high, 2 from the LFSR
	task automatic run_cycles(int n, int cond_mode);
		instr_t word;
		opcode_t op;
		logic [pc_width-1:0] imm;
		logic [pc_width-1:0] next_pc;
		logic live;
		logic save_exp;
		logic c;
		for (int i = 0; i < n; i++) begin
			// Past the end of memory reads as nop
			word = (m_pc < depth) ? prog[m_pc] : '0;
			op = (word[31:28] <= 4'h4) ? opcode_t'(word[31:28]) : op_nop;
			imm = pc_width'($signed(word[15:0]));
			// Slot after a taken branch is squashed
			live = !m_pend;
			save_exp = live && (op == op_jal || op == op_jalr || op == op_auipc);
			check_pc("pc", m_pc, pc);
			check_bit("redirect", m_pend, redirect);
			check_bit("save_valid", save_exp, save_valid);
			if (save_exp) begin
				check_save("pc_save", (op == op_auipc) ? m_pc + imm : m_pc + 1'b1, pc_save);
			end
			c = (cond_mode == 0) ? 1'b0 : (cond_mode == 1) ? 1'b1 : lfsr_bit();
			cond = c;
			if (m_pend) next_pc = m_tgt;
			else if (live && (op == op_jal || op == op_jalr)) next_pc = m_pc + imm;
			else next_pc = m_pc + 1'b1;
			if (live && op == op_beq) m_tgt = m_pc + imm;
			m_pend = live && op == op_beq && c;
			m_pc = next_pc;
			@(negedge clk);
		end
	endtask

	////////////////////
	// Directed tests

	task automatic test_straight_line();
		clear_program();
		do_reset();
		load_program();
		run_cycles(20, 2);
	endtask

	task automatic test_jumps();
		clear_program();
		prog[1] = make_word(op_jal, 29);
		// Backward jalr into the 3 to 10 range
		prog[30] = make_word(op_jalr, -(20 + lfsr_bits(3)));
		prog[11] = make_word(op_jal, 30 + lfsr_bits(3));
		do_reset();
		load_program();
		run_cycles(30, 0);
	endtask

	task automatic test_auipc();
		clear_program();
		prog[1] = make_word(op_auipc, 16'h0100);
		prog[2] = make_word(op_auipc, -3);
		prog[4] = make_word(op_auipc, lfsr_bits(8));
		do_reset();
		load_program();
		run_cycles(8, 0);
	endtask

	task automatic test_branches();
		clear_program();
		prog[1] = make_word(op_beq, 6);
		// Wrong-path slots after each taken branch
		prog[2] = make_word(op_jal, 20);
		prog[7] = make_word(op_beq, -7);
		prog[8] = make_word(op_auipc, 5);
		do_reset();
		load_program();
		run_cycles(12, 0);
		do_reset();
		run_cycles(10, 1);
		do_reset();
		run_cycles(30, 2);
	endtask

	// Load lands between a taken branch and its redirect
	task automatic test_load_stall();
		clear_program();
		prog[1] = make_word(op_beq, 9);
		prog[2] = make_word(op_jal, 4);
		do_reset();
		load_program();
		run_cycles(2, 1);
		// Word written mid-run is fetched soon after the redirect
		load_word(12, make_word(op_auipc, 7));
		run_cycles(6, 0);
	endtask

	initial begin
		error_count = 0;
		lfsr_state = 32'h5f82;
		reset = 1'b0;
		cond = 1'b0;
		load_req = 1'b0;
		load_addr = '0;
		load_data = '0;
		test_straight_line();
		test_jumps();
		test_auipc();
		test_branches();
		test_load_stall();
		$display("Checks finished with %0d value errors", error_count);
		if (error_count == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
